/* include/iq_config.svh */
/*
 * Issue queue sizing macros: queue depth, head/tail index width, datapath width
 */

`ifndef IQ_CONFIG_SVH
`define IQ_CONFIG_SVH

// Number of queue slots
// Must be a power of two
`define IQ_DEPTH 8

// Head and tail index width, log2 of the depth
`define IQ_IDX_LEN 3

// Program counter and immediate width
`define IQ_XLEN 32

`endif

/* logic/iq_pkg.sv */
/*
 * Issue queue types: R/I instruction views and their union,
 * fetch payload, stored slot and issued operand bundle
 */

`default_nettype none

`include "iq_config.svh"

package iq_pkg;

    // Register-register major opcode
    localparam logic [6:0] OPCODE_OP = 7'b0110011;

    // R-type layout of the instruction word
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } iq_rtype_t;

    // I-type layout, 12-bit immediate in place of funct7/rs2
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iq_itype_t;

    // Same 32-bit word, read either way
    typedef union packed {
        iq_rtype_t rtype;
        iq_itype_t itype;
    } iq_instr_u;

    // What fetch hands over
    typedef struct packed {
        logic [`IQ_XLEN-1:0] pc;
        iq_instr_u           instr;
    } iq_fetch_t;

    // One queue slot
    typedef struct packed {
        logic      valid;
        iq_fetch_t fetch;
    } iq_entry_t;

    // Issued instruction with its operands split out
    typedef struct packed {
        logic [`IQ_XLEN-1:0] pc;
        logic [6:0]          opcode;
        logic [4:0]          rd;
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        logic [`IQ_XLEN-1:0] imm;
        logic                uses_imm;
    } iq_issue_t;

endpackage

`default_nettype wire

/* logic/iq_ptr_counter.sv */
/*
 * Modulo-depth queue index counter with enable and synchronous clear
 */

`timescale 1ns/1ps
`default_nettype none

`include "iq_config.svh"

module iq_ptr_counter (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   en_i,
    input  logic                   clr_i,
    output logic [`IQ_IDX_LEN-1:0] cnt_o
);

    logic [`IQ_IDX_LEN-1:0] cnt_q;
    logic [`IQ_IDX_LEN-1:0] cnt_d;

    // Next index, clear has priority over increment
    always_comb begin
        cnt_d = cnt_q;
        if (clr_i) begin
            cnt_d = '0;
        end else if (en_i) begin
            // Wrap after the last slot
            if (cnt_q == `IQ_IDX_LEN'(`IQ_DEPTH - 1)) begin
                cnt_d = '0;
            end else begin
                cnt_d = cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_d;
        end
    end

    assign cnt_o = cnt_q;

endmodule

`default_nettype wire

/* logic/issue_queue_fifo.sv */
/*
 * Issue queue storage with valid bits, fetch/issue handshake control
 * and head/tail counter strobes
 */

`timescale 1ns/1ps
`default_nettype none

`include "iq_config.svh"

module issue_queue_fifo (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   flush_i,
    // Fetch side handshake
    input  logic                   fetch_valid_i,
    output logic                   fetch_ready_o,
    input  iq_pkg::iq_fetch_t      fetch_data_i,
    // Execution pipeline side handshake
    input  logic                   issue_ready_i,
    output logic                   issue_valid_o,
    output iq_pkg::iq_fetch_t      head_fetch_o,
    // Pointer counters
    input  logic [`IQ_IDX_LEN-1:0] head_idx_i,
    input  logic [`IQ_IDX_LEN-1:0] tail_idx_i,
    output logic                   head_cnt_en_o,
    output logic                   tail_cnt_en_o,
    output logic                   head_cnt_clr_o,
    output logic                   tail_cnt_clr_o
);
    import iq_pkg::*;

    // Occupancy, one bit per slot
    logic [`IQ_DEPTH-1:0] valid_q;
    // Instruction payloads, only written on push
    iq_fetch_t            data_q [`IQ_DEPTH];
    // Slots as seen by the read port
    iq_entry_t            slots [`IQ_DEPTH];
    iq_entry_t            head_entry;

    logic                 fifo_full;
    logic                 fifo_push;
    logic                 fifo_pop;

    // Join valid bits and payloads into slot records
    always_comb begin
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            slots[i].valid = valid_q[i];
            slots[i].fetch = data_q[i];
        end
    end

    // Full when every slot holds an instruction
    assign fifo_full  = &valid_q;
    assign head_entry = slots[head_idx_i];

    // Handshake control
    always_comb begin
        issue_valid_o = 1'b0;
        fetch_ready_o = 1'b0;
        fifo_pop      = 1'b0;
        fifo_push     = 1'b0;
        // Both sides are blocked during a flush
        if (!flush_i) begin
            if (head_entry.valid) begin
                issue_valid_o = 1'b1;
                fifo_pop      = issue_ready_i;
            end
            // A full queue still accepts when the head leaves this cycle
            if (!fifo_full || fifo_pop) begin
                fetch_ready_o = 1'b1;
                fifo_push     = fetch_valid_i;
            end
        end
    end

    // Counter strobes
    assign head_cnt_en_o  = fifo_pop;
    assign tail_cnt_en_o  = fifo_push;
    assign head_cnt_clr_o = flush_i;
    assign tail_cnt_clr_o = flush_i;

    // Valid bit update
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
        end else begin
            if (fifo_pop) begin
                valid_q[head_idx_i] <= 1'b0;
            end
            // Push after pop, so a full queue refills the freed head slot
            if (fifo_push) begin
                valid_q[tail_idx_i] <= 1'b1;
            end
        end
    end

    // Payload write port
    always_ff @(posedge clk_i) begin
        if (fifo_push) begin
            data_q[tail_idx_i] <= fetch_data_i;
        end
    end

    // Read port, head slot to the operand extractor
    assign head_fetch_o = head_entry.fetch;

endmodule

`default_nettype wire

/* logic/iq_operand_extract.sv */
/*
 * Operand extraction of the head instruction: register indices,
 * sign-extended immediate and immediate-use flag
 */

`timescale 1ns/1ps
`default_nettype none

`include "iq_config.svh"

module iq_operand_extract (
    input  iq_pkg::iq_fetch_t head_fetch_i,
    output iq_pkg::iq_issue_t issue_o
);
    import iq_pkg::*;

    iq_instr_u  head_instr;
    logic [6:0] head_opcode;

    assign head_instr  = head_fetch_i.instr;
    // Opcode sits at the same bits in both views
    assign head_opcode = head_instr.rtype.opcode;

    always_comb begin
        // Fields common to both formats
        issue_o.pc     = head_fetch_i.pc;
        issue_o.opcode = head_opcode;
        issue_o.rd     = head_instr.rtype.rd;
        issue_o.rs1    = head_instr.rtype.rs1;

        if (head_opcode == OPCODE_OP) begin
            // Register-register, second source from rs2
            issue_o.rs2      = head_instr.rtype.rs2;
            issue_o.imm      = '0;
            issue_o.uses_imm = 1'b0;
        end else begin
            // Immediate form, sign extend imm12
            issue_o.rs2      = '0;
            issue_o.imm      = {{(`IQ_XLEN - 12){head_instr.itype.imm12[11]}},
                                head_instr.itype.imm12};
            issue_o.uses_imm = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* logic/issue_queue.sv */
/*
 * Issue queue top: storage/control, head and tail counters, operand extractor
 */

`timescale 1ns/1ps
`default_nettype none

`include "iq_config.svh"

module issue_queue (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              flush_i,
    // From fetch
    input  logic              fetch_valid_i,
    input  iq_pkg::iq_fetch_t fetch_data_i,
    output logic              fetch_ready_o,
    // To execution pipeline
    input  logic              issue_ready_i,
    output logic              issue_valid_o,
    output iq_pkg::iq_issue_t issue_data_o
);
    import iq_pkg::*;

    // Counter strobes from the control logic
    logic                   head_cnt_en;
    logic                   tail_cnt_en;
    logic                   head_cnt_clr;
    logic                   tail_cnt_clr;
    // Current queue indices
    logic [`IQ_IDX_LEN-1:0] head_idx;
    logic [`IQ_IDX_LEN-1:0] tail_idx;
    // Head slot payload
    iq_fetch_t              head_fetch;

    issue_queue_fifo u_fifo (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .fetch_valid_i  (fetch_valid_i),
        .fetch_ready_o  (fetch_ready_o),
        .fetch_data_i   (fetch_data_i),
        .issue_ready_i  (issue_ready_i),
        .issue_valid_o  (issue_valid_o),
        .head_fetch_o   (head_fetch),
        .head_idx_i     (head_idx),
        .tail_idx_i     (tail_idx),
        .head_cnt_en_o  (head_cnt_en),
        .tail_cnt_en_o  (tail_cnt_en),
        .head_cnt_clr_o (head_cnt_clr),
        .tail_cnt_clr_o (tail_cnt_clr)
    );

    // Read pointer
    iq_ptr_counter u_head_cnt (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .en_i    (head_cnt_en),
        .clr_i   (head_cnt_clr),
        .cnt_o   (head_idx)
    );

    // Write pointer
    iq_ptr_counter u_tail_cnt (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .en_i    (tail_cnt_en),
        .clr_i   (tail_cnt_clr),
        .cnt_o   (tail_idx)
    );

    iq_operand_extract u_extract (
        .head_fetch_i (head_fetch),
        .issue_o      (issue_data_o)
    );

endmodule

`default_nettype wire

/* dv/tb_issue_queue.sv */
/*
 * Issue queue testbench: random fetch/issue/flush traffic against a
 * reference queue model, back-pressure, full and flush scenarios
 */

`timescale 1ns/1ps
`default_nettype none

`include "iq_config.svh"

module tb_issue_queue;
    import iq_pkg::*;

    localparam int WAIT_LIMIT  = 100;
    localparam int RAND_CYCLES = 800;

    logic      clk_i;
    logic      rst_n_i;
    logic      flush_i;
    logic      fetch_valid_i;
    iq_fetch_t fetch_data_i;
    logic      fetch_ready_o;
    logic      issue_ready_i;
    logic      issue_valid_o;
    iq_issue_t issue_data_o;

    // Reference queue, front is the next instruction to issue
    iq_fetch_t   model_q [$];
    logic [31:0] rng_state = 32'he370;
    // Handshakes seen on the DUT ports in the last cycle
    logic        last_push;
    logic        last_pop;
    logic        seen_ready;
    int          issued;
    int          neg_imm_seen;
    int          pos_imm_seen;

    issue_queue uut (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .fetch_valid_i (fetch_valid_i),
        .fetch_data_i  (fetch_data_i),
        .fetch_ready_o (fetch_ready_o),
        .issue_ready_i (issue_ready_i),
        .issue_valid_o (issue_valid_o),
        .issue_data_o  (issue_data_o)
    );

    always #2 clk_i = ~clk_i;

    // 32-bit xorshift generator
    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    // Random pc and word, about half register-register
    function automatic iq_fetch_t random_fetch();
        iq_fetch_t   f;
        logic [31:0] w;
        logic [31:0] sel;
        w   = next_rand();
        sel = next_rand();
        if (sel[0]) begin
            w[6:0] = OPCODE_OP;
        end else begin
            w[6:0] = sel[1] ? 7'b0010011 : 7'b0000011;
        end
        f.pc    = next_rand();
        f.instr = w;
        return f;
    endfunction

    // Extraction rule, straight from the instruction bit positions
    function automatic iq_issue_t expected_issue(input iq_fetch_t f);
        iq_issue_t   e;
        logic [31:0] w;
        w        = f.instr;
        e.pc     = f.pc;
        e.opcode = w[6:0];
        e.rd     = w[11:7];
        e.rs1    = w[19:15];
        if (w[6:0] == 7'b0110011) begin
            e.rs2      = w[24:20];
            e.imm      = '0;
            e.uses_imm = 1'b0;
        end else begin
            e.rs2      = '0;
            e.imm      = {{(`IQ_XLEN - 12){w[31]}}, w[31:20]};
            e.uses_imm = 1'b1;
        end
        return e;
    endfunction

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %0t ns %s expected %b got %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_issue(input string name, input iq_issue_t exp, input iq_issue_t act);
        if (act !== exp) begin
            $display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    // One clock: drive after the edge, check at the falling edge, update the model
    task automatic run_cycle(input logic fv, input iq_fetch_t fd, input logic ir, input logic fl);
        logic exp_valid;
        logic exp_ready;
        logic exp_pop;
        logic exp_push;
        @(posedge clk_i);
        #1;
        fetch_valid_i = fv;
        fetch_data_i  = fd;
        issue_ready_i = ir;
        flush_i       = fl;
        @(negedge clk_i);
        exp_valid = !fl && (model_q.size() != 0);
        exp_pop   = exp_valid && ir;
        // Full queue still takes a push when the head leaves
        exp_ready = !fl && ((model_q.size() < `IQ_DEPTH) || exp_pop);
        exp_push  = exp_ready && fv;
        check_bit("issue_valid_o", exp_valid, issue_valid_o);
        check_bit("fetch_ready_o", exp_ready, fetch_ready_o);
        if (exp_valid) begin
            check_issue("issue_data_o", expected_issue(model_q[0]), issue_data_o);
        end
        if (exp_pop) begin
            // Track which immediate signs went through the I-type path
            if (model_q[0].instr[6:0] != OPCODE_OP) begin
                if (model_q[0].instr[31]) begin
                    neg_imm_seen++;
                end else begin
                    pos_imm_seen++;
                end
            end
            void'(model_q.pop_front());
            issued++;
        end
        if (exp_push) begin
            model_q.push_back(fd);
        end
        if (fl) begin
            model_q.delete();
        end
        last_push  = fv && fetch_ready_o && !fl;
        last_pop   = ir && issue_valid_o && !fl;
        seen_ready = fetch_ready_o;
    endtask

    // Pop until the model is empty
    task automatic drain_queue();
        int n;
        n = 0;
        while (model_q.size() != 0) begin
            if (n == WAIT_LIMIT) begin
                $display("Timeout at %0t ns, queue did not drain", $time);
                abort_run();
            end
            run_cycle(1'b0, random_fetch(), 1'b1, 1'b0);
            n++;
        end
    endtask

    // Push with issue stalled until fetch_ready_o drops
    task automatic fill_queue(output int pushed);
        int n;
        n      = 0;
        pushed = 0;
        seen_ready = 1'b1;
        while (seen_ready) begin
            if (n == WAIT_LIMIT) begin
                $display("Timeout at %0t ns, fetch_ready_o never went low", $time);
                abort_run();
            end
            run_cycle(1'b1, random_fetch(), 1'b0, 1'b0);
            if (last_push) begin
                pushed++;
            end
            n++;
        end
    endtask

    initial begin
        int pushed;
        int r;
        clk_i         = 1'b0;
        rst_n_i       = 1'b0;
        flush_i       = 1'b0;
        fetch_valid_i = 1'b0;
        fetch_data_i  = '0;
        issue_ready_i = 1'b0;
        issued        = 0;
        neg_imm_seen  = 0;
        pos_imm_seen  = 0;
        repeat (5) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        @(negedge clk_i);
        check_bit("issue_valid_o", 1'b0, issue_valid_o);
        check_bit("fetch_ready_o", 1'b1, fetch_ready_o);

        // Back-pressure up to full, then a pop and push in the same cycle
        fill_queue(pushed);
        if (pushed != `IQ_DEPTH) begin
            $display("Queue accepted %0d pushes while stalled, not %0d", pushed, `IQ_DEPTH);
            abort_run();
        end
        run_cycle(1'b1, random_fetch(), 1'b1, 1'b0);
        check_bit("fetch_ready_o", 1'b1, seen_ready);
        check_bit("push", 1'b1, last_push);
        check_bit("pop", 1'b1, last_pop);
        // Still full afterwards, the push refilled the slot freed by the pop
        run_cycle(1'b1, random_fetch(), 1'b0, 1'b0);

        // Flush a full queue, both sides blocked, then empty and ready
        run_cycle(1'b1, random_fetch(), 1'b1, 1'b1);
        run_cycle(1'b0, random_fetch(), 1'b0, 1'b0);
        check_bit("issue_valid_o", 1'b0, issue_valid_o);
        check_bit("fetch_ready_o", 1'b1, fetch_ready_o);

        // Long random run, pointers wrap many times
        for (int c = 0; c < RAND_CYCLES; c++) begin
            r = next_rand();
            run_cycle(r[1:0] != 2'b00, random_fetch(), r[3:2] != 2'b00, r[9:4] == 6'd0);
        end
        drain_queue();

        if (issued <= 4 * `IQ_DEPTH || neg_imm_seen == 0 || pos_imm_seen == 0) begin
            $display("Too little traffic: %0d issued, %0d negative and %0d positive immediates",
                     issued, neg_imm_seen, pos_imm_seen);
            abort_run();
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+include
logic/iq_pkg.sv
logic/iq_ptr_counter.sv
logic/issue_queue_fifo.sv
logic/iq_operand_extract.sv
logic/issue_queue.sv
dv/tb_issue_queue.sv

/* Bender.yml */
package:
  name: issue_queue

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/iq_pkg.sv
      - logic/iq_ptr_counter.sv
      - logic/issue_queue_fifo.sv
      - logic/iq_operand_extract.sv
      - logic/issue_queue.sv
      - target: test
        files:
          - dv/tb_issue_queue.sv
